/* source/c4_cfg.svh */
// cycle counts are sized for simulation; scale the phase and step counts and widen the timer for a 50 MHz board
`ifndef C4_CFG_SVH
`define C4_CFG_SVH

// board geometry
`define C4_SWITCH_COUNT 10 // switches and red leds
`define C4_COLUMN_COUNT 7 // playable columns, switches 0 to 6
`define C4_COLUMN_WIDTH 4 // column index, wide enough for a hex digit

// error flash, alternating on and off phases starting with on
`define C4_FLASH_PHASE_CYCLES 8 // about 25000000 on the board for half a second
`define C4_FLASH_PHASES 6

// chase, one lit led walking from led 9 to led 0
`define C4_CHASE_STEP_CYCLES 4 // about 10000000 on the board
`define C4_CHASE_STEPS 10

// effect timer counts a whole effect
// 6 x 8 = 48 flash cycles and 10 x 4 = 40 chase cycles fit in 8 bits
// board values of 150000000 cycles need 28 bits
`define C4_TIMER_WIDTH 8

`endif

/* source/c4Pkg.sv */
// types only; widths come from the cfg header, which must be on the include path
`default_nettype none

`include "c4_cfg.svh"

package c4Pkg;

	typedef logic [`C4_SWITCH_COUNT-1:0] switchVec_t; // one bit per switch or led
	typedef logic [`C4_COLUMN_WIDTH-1:0] column_t; // column index 0 to 6
	typedef logic [6:0] segments_t; // gfedcba, active low
	typedef logic [`C4_TIMER_WIDTH-1:0] effectTimer_t; // cycles since effect start

	// what the led register shows
	typedef enum logic [1:0] {
		modeMirror, // copy of switches 0 to 6
		modeErrorFlash, // all on, all off
		modeChase, // single led walking down
		modeHold // keep last value
	} ledMode_t;

	// column entry controller
	typedef enum logic [2:0] {
		stWaiting, // wait for load
		stCheck, // one cycle, decoder verdict
		stErrorFlash,
		stChase,
		stOffer // column on valid/ready output
	} ctrlState_t;

endpackage

`default_nettype wire

/* source/effectCtrlIf.sv */
// no clock inside; both sides sample it on their own CLOCK_50
`timescale 1ns/10ps
`default_nettype none

interface effectCtrlIf import c4Pkg::*; ();

	ledMode_t mode; // led mode, follows controller state
	logic effectStart; // one cycle, flash or chase begins
	logic effectDone; // one cycle, last cycle of the effect
	logic captureColumn; // with effectDone at the end of a chase only

	modport controller (
		output mode,
		output effectStart,
		input effectDone
	);

	// captureColumn also leaves the sequencer toward the column port
	modport sequencer (
		input mode,
		input effectStart,
		output effectDone,
		output captureColumn
	);

endinterface

`default_nettype wire

/* source/switchDecoder.sv */
// purely combinational; any switch among 7 to 9 rejects the choice
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module switchDecoder import c4Pkg::*; (
	input switchVec_t sw,
	output logic choiceValid,
	output column_t choiceColumn
);

	logic [$clog2(`C4_COLUMN_COUNT + 1)-1:0] activeCount; // 0 to 7 switches on
	column_t foundColumn; // highest active column switch
	logic upperActive;

	// count the column switches and note where one is on
	always_comb begin
		activeCount = '0;
		foundColumn = '0;
		for (int i = 0; i < `C4_COLUMN_COUNT; i++) begin
			if (sw[i]) begin
				activeCount = activeCount + 1'b1;
				foundColumn = column_t'(i);
			end
		end
	end

	// switches past the last column
	assign upperActive = |sw[`C4_SWITCH_COUNT-1:`C4_COLUMN_COUNT];

	// exactly one, and nothing above
	assign choiceValid = (activeCount == 1) && !upperActive;

	// zero unless the pattern is legal
	assign choiceColumn = choiceValid ? foundColumn : '0;

endmodule

`default_nettype wire

/* source/columnControl.sv */
// loadPress is a level; held through a whole effect it starts another check on return to waiting
`timescale 1ns/10ps
`default_nettype none

module columnControl import c4Pkg::*; (
	input logic CLOCK_50,
	input logic reset, // sync, active low
	input logic loadPress, // active high level
	input logic choiceValid, // decoder verdict
	input logic columnValid, // from the column port output
	input logic columnReady,
	effectCtrlIf.controller effect
);

	ctrlState_t state;
	ctrlState_t nextState;
	logic transferDone;

	// handshake completes on this edge
	assign transferDone = columnValid && columnReady;

	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			state <= stWaiting;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state; // stay by default
		case (state)
			stWaiting: begin
				if (loadPress) begin
					nextState = stCheck;
				end
			end
			stCheck: begin
				// one cycle only, verdict picks the effect
				if (choiceValid) begin
					nextState = stChase;
				end else begin
					nextState = stErrorFlash;
				end
			end
			stErrorFlash: begin
				if (effect.effectDone) begin
					nextState = stWaiting; // back to mirror
				end
			end
			stChase: begin
				if (effect.effectDone) begin
					nextState = stOffer; // column captured on this edge
				end
			end
			stOffer: begin
				// loadPress ignored until the engine takes the column
				if (transferDone) begin
					nextState = stWaiting;
				end
			end
			default: nextState = stWaiting;
		endcase
	end

	// effect begins on the edge that leaves check
	assign effect.effectStart = (state == stCheck);

	// led mode follows the state
	always_comb begin
		case (state)
			stWaiting: effect.mode = modeMirror;
			stErrorFlash: effect.mode = modeErrorFlash;
			stChase: effect.mode = modeChase;
			default: effect.mode = modeHold; // check and offer freeze the leds
		endcase
	end

endmodule

`default_nettype wire

/* source/ledSequencer.sv */
// leds lag their source by one register stage; divisions are by constants from the cfg header
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module ledSequencer import c4Pkg::*; (
	input logic CLOCK_50,
	input logic reset, // sync, active low
	input switchVec_t sw,
	effectCtrlIf.sequencer effect,
	output switchVec_t ledr
);

	// whole effect lengths in cycles
	localparam int FlashLength = `C4_FLASH_PHASES * `C4_FLASH_PHASE_CYCLES;
	localparam int ChaseLength = `C4_CHASE_STEPS * `C4_CHASE_STEP_CYCLES;

	// only the column switches show in mirror mode
	localparam switchVec_t MirrorMask = switchVec_t'((1 << `C4_COLUMN_COUNT) - 1);

	effectTimer_t timer; // cycles since effectStart
	effectTimer_t phaseIndex; // flash phase, even is on
	effectTimer_t stepIndex; // chase position, 0 is led 9
	effectTimer_t chaseBit; // led number lit by the chase
	logic flashLast;
	logic chaseLast;
	switchVec_t flashPattern;
	switchVec_t chasePattern;

	assign phaseIndex = timer / effectTimer_t'(`C4_FLASH_PHASE_CYCLES);
	assign stepIndex = timer / effectTimer_t'(`C4_CHASE_STEP_CYCLES);
	assign chaseBit = effectTimer_t'(`C4_SWITCH_COUNT - 1) - stepIndex;

	assign flashPattern = phaseIndex[0] ? '0 : '1; // starts lit
	assign chasePattern = switchVec_t'(1) << chaseBit; // one-hot

	// last cycle of each effect
	assign flashLast = (effect.mode == modeErrorFlash) &&
		(timer == effectTimer_t'(FlashLength - 1));
	assign chaseLast = (effect.mode == modeChase) &&
		(timer == effectTimer_t'(ChaseLength - 1));

	assign effect.effectDone = flashLast || chaseLast;
	assign effect.captureColumn = chaseLast; // only a chase yields a column

	// effect timer
	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			timer <= '0;
		end else if (effect.effectStart) begin
			timer <= '0; // restart, mode switches on the same edge
		end else if (effect.mode == modeErrorFlash || effect.mode == modeChase) begin
			timer <= timer + 1'b1; // mode ends before wrap
		end
	end

	// led register
	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			ledr <= '0;
		end else begin
			case (effect.mode)
				modeMirror: ledr <= sw & MirrorMask; // 7 to 9 dark
				modeErrorFlash: ledr <= flashPattern;
				modeChase: ledr <= chasePattern;
				default: ledr <= ledr; // hold
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/columnPort.sv */
// column is taken from the live decoder at the end of the chase, so switches must not move during it
`timescale 1ns/10ps
`default_nettype none

module columnPort import c4Pkg::*; (
	input logic CLOCK_50,
	input logic reset, // sync, active low
	input logic captureColumn, // end of chase
	input column_t choiceColumn,
	input logic columnReady,
	output column_t column,
	output logic columnValid,
	output segments_t hex0
);

	// column register and valid flag
	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			column <= '0;
			columnValid <= 1'b0;
		end else if (captureColumn) begin
			column <= choiceColumn;
			columnValid <= 1'b1; // offered from the next cycle
		end else if (columnValid && columnReady) begin
			columnValid <= 1'b0; // transfer done, column kept for the display
		end
	end

	// hex digit of the register, gfedcba active low
	always_comb begin
		case (column)
			4'h0: hex0 = 7'b1000000;
			4'h1: hex0 = 7'b1111001;
			4'h2: hex0 = 7'b0100100;
			4'h3: hex0 = 7'b0110000;
			4'h4: hex0 = 7'b0011001;
			4'h5: hex0 = 7'b0010010;
			4'h6: hex0 = 7'b0000010;
			4'h7: hex0 = 7'b1111000;
			4'h8: hex0 = 7'b0000000;
			4'h9: hex0 = 7'b0010000;
			4'hA: hex0 = 7'b0001000;
			4'hB: hex0 = 7'b0000011; // lower case b
			4'hC: hex0 = 7'b1000110;
			4'hD: hex0 = 7'b0100001; // lower case d
			4'hE: hex0 = 7'b0000110;
			default: hex0 = 7'b0001110; // F
		endcase
	end

endmodule

`default_nettype wire

/* source/connectFourInput.sv */
// reset is synchronous and active low; on the board tie it to KEY0 and loadPress to an inverted KEY3
`timescale 1ns/10ps
`default_nettype none

module connectFourInput import c4Pkg::*; (
	input logic CLOCK_50,
	input logic reset, // sync, active low
	input switchVec_t sw,
	input logic loadPress, // active high level
	input logic columnReady, // game engine takes the column
	output switchVec_t ledr,
	output segments_t hex0,
	output column_t column,
	output logic columnValid
);

	logic choiceValid;
	column_t choiceColumn;

	effectCtrlIf effectIf (); // controller to led sequencer

	switchDecoder switchDecoder_i (
		.sw(sw),
		.choiceValid(choiceValid),
		.choiceColumn(choiceColumn)
	);

	columnControl columnControl_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.loadPress(loadPress),
		.choiceValid(choiceValid),
		.columnValid(columnValid), // back from the port output
		.columnReady(columnReady),
		.effect(effectIf.controller)
	);

	ledSequencer ledSequencer_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.sw(sw),
		.effect(effectIf.sequencer),
		.ledr(ledr)
	);

	columnPort columnPort_i (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.captureColumn(effectIf.captureColumn),
		.choiceColumn(choiceColumn),
		.columnReady(columnReady),
		.column(column),
		.columnValid(columnValid),
		.hex0(hex0)
	);

endmodule

`default_nettype wire

/* tb/clockGen.sv */
// free-running 40 ns clock; reset held low for the first 10 rising edges, then released
`timescale 1ns/10ps
`default_nettype none

module clockGen (
	output logic CLOCK_50,
	output logic reset // sync, active low
);

	initial begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50; // half period
	end

	initial begin
		reset = 1'b0;
		repeat (10) @(posedge CLOCK_50);
		reset <= 1'b1; // released on a rising edge
	end

endmodule

`default_nettype wire

/* tb/connectFourInput_sva.sv */
// sampled on CLOCK_50; expects the synchronous active low reset of the design
`timescale 1ns/10ps
`default_nettype none

module connectFourInput_sva import c4Pkg::*; (
	input logic CLOCK_50,
	input logic reset,
	input column_t column,
	input logic columnValid,
	input logic columnReady
);

	// sync reset clears the flag on the next edge
	validLowInReset: assert property (@(posedge CLOCK_50)
		!reset |=> !columnValid)
		else $error("columnValid high after a reset cycle");

	// offer stays put while the engine stalls
	holdWhileStalled: assert property (@(posedge CLOCK_50) disable iff (!reset)
		columnValid && !columnReady |=> columnValid && $stable(column))
		else $error("column offer changed while columnReady was low");

	// valid only drops after valid and ready met
	dropAfterTransfer: assert property (@(posedge CLOCK_50) disable iff (!reset)
		$fell(columnValid) |-> $past(columnReady))
		else $error("columnValid fell without a completed transfer");

endmodule

`default_nettype wire

/* tb/connectFourInput_tb.sv */
// needs the short simulation cycle counts of c4_cfg.svh; switches stay still during each load
`timescale 1ns/10ps
`default_nettype none

`include "c4_cfg.svh"

module connectFourInput_tb import c4Pkg::*; ();

	typedef struct packed {
		switchVec_t pattern;
		logic accept; // exactly one of 0 to 6, nothing above
		column_t col;
		segments_t hex; // active low gfedcba digit of col
		logic [7:0] delay; // ready delay from the lcg
	} row_t;

	localparam switchVec_t ColumnMask = 10'h07F; // leds 7 to 9 dark in mirror
	localparam switchVec_t ProbePattern = 10'h055; // shows the return to mirroring
	localparam int ChaseTimeout = `C4_CHASE_STEPS * `C4_CHASE_STEP_CYCLES + 8;
	localparam int FlashTimeout = `C4_FLASH_PHASES * `C4_FLASH_PHASE_CYCLES + 12;

	logic CLOCK_50;
	logic reset;
	switchVec_t sw;
	logic loadPress;
	logic columnReady;
	switchVec_t ledr;
	segments_t hex0;
	column_t column;
	logic columnValid;
	int errors = 0;
	logic [31:0] seed = 32'hea986ddc;

	// col and hex unused on rejected rows
	row_t rows [0:10] = '{
		'{10'h001, 1'b1, 4'd0, 7'b1000000, 8'd0},
		'{10'h000, 1'b0, 4'd0, 7'b0000000, 8'd0}, // nothing on
		'{10'h002, 1'b1, 4'd1, 7'b1111001, 8'd0},
		'{10'h003, 1'b0, 4'd0, 7'b0000000, 8'd0}, // two columns
		'{10'h004, 1'b1, 4'd2, 7'b0100100, 8'd0},
		'{10'h080, 1'b0, 4'd0, 7'b0000000, 8'd0}, // switch 7 alone
		'{10'h008, 1'b1, 4'd3, 7'b0110000, 8'd0},
		'{10'h201, 1'b0, 4'd0, 7'b0000000, 8'd0}, // column plus switch 9
		'{10'h010, 1'b1, 4'd4, 7'b0011001, 8'd0},
		'{10'h020, 1'b1, 4'd5, 7'b0010010, 8'd0},
		'{10'h040, 1'b1, 4'd6, 7'b0000010, 8'd0}
	};

	clockGen clockGen_i (.*);
	connectFourInput connectFourInput_i (.*);
	bind connectFourInput connectFourInput_sva connectFourInput_sva_i (.*);

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	// chase, offer, stall and transfer of one accepted row
	task automatic runAccepted(input int r);
		switchVec_t prevLed;
		switchVec_t seen [$];
		column_t heldColumn;
		int cycles;
		prevLed = rows[r].pattern & ColumnMask; // mirror before the chase
		cycles = 0;
		while (!columnValid && cycles < ChaseTimeout) begin
			@(negedge CLOCK_50);
			cycles++;
			if (ledr != prevLed && ledr != '0) begin
				seen.push_back(ledr); // each new chase position
			end
			prevLed = ledr;
		end
		if (!columnValid) begin
			$display("row %0d: columnValid never rose after an accepted load", r);
			errors++;
		end
		compare($sformatf("row %0d chase length", r), 32'(`C4_CHASE_STEPS), 32'(seen.size()));
		foreach (seen[k]) begin
			compare($sformatf("row %0d chase step %0d", r, k),
				32'(switchVec_t'(1) << (`C4_SWITCH_COUNT - 1 - k)), 32'(seen[k]));
		end
		compare($sformatf("row %0d column", r), 32'(rows[r].col), 32'(column));
		heldColumn = column;
		repeat (rows[r].delay) begin
			@(posedge CLOCK_50);
			loadPress <= 1'b1; // offer state must ignore it
			@(negedge CLOCK_50);
			compare($sformatf("row %0d valid held", r), 32'd1, 32'(columnValid));
			compare($sformatf("row %0d column held", r), 32'(heldColumn), 32'(column));
		end
		@(posedge CLOCK_50);
		loadPress <= 1'b0;
		columnReady <= 1'b1;
		cycles = 0;
		while (columnValid && cycles < 4) begin
			@(negedge CLOCK_50);
			cycles++;
		end
		if (columnValid) begin
			$display("row %0d: columnValid stayed high after columnReady rose", r);
			errors++;
		end
		@(posedge CLOCK_50);
		columnReady <= 1'b0;
		@(negedge CLOCK_50);
		compare($sformatf("row %0d hex0", r), 32'(rows[r].hex), 32'(hex0));
		// a load taken during the offer would show a chase here
		compare($sformatf("row %0d mirror after transfer", r),
			32'(rows[r].pattern & ColumnMask), 32'(ledr));
	endtask

	// error flash of one rejected row, then a probe pattern to see mirroring again
	task automatic runRejected(input int r);
		int cycles;
		int onCount;
		logic wasOn;
		logic probeDue;
		logic probed;
		cycles = 0;
		onCount = 0;
		wasOn = 1'b0;
		probeDue = 1'b0;
		probed = 1'b0;
		while (!(probed && ledr == ProbePattern) && cycles < FlashTimeout) begin
			@(posedge CLOCK_50);
			if (probeDue && !probed) begin
				sw <= ProbePattern; // decoder only matters in check
				probed = 1'b1;
			end
			@(negedge CLOCK_50);
			cycles++;
			compare($sformatf("row %0d valid low", r), 32'd0, 32'(columnValid));
			if (ledr == '1 && !wasOn) begin
				onCount++; // start of a lit phase
			end
			wasOn = (ledr == '1);
			if (onCount == `C4_FLASH_PHASES / 2 && ledr == '0) begin
				probeDue = 1'b1; // last dark phase reached
			end
		end
		compare($sformatf("row %0d lit phases", r), 32'(`C4_FLASH_PHASES / 2), 32'(onCount));
		if (!(probed && ledr == ProbePattern)) begin
			$display("row %0d: leds did not return to mirroring after the flash", r);
			errors++;
		end
	endtask

	initial begin
		int cycles;
		sw = '0;
		loadPress = 1'b0;
		columnReady = 1'b0;
		foreach (rows[r]) begin
			seed = nextRandom(seed);
			rows[r].delay = 8'((seed >> 24) % 32'd6) + 8'd1; // 1 to 6 cycles
		end
		cycles = 0;
		while (reset !== 1'b1 && cycles < 20) begin
			@(posedge CLOCK_50);
			cycles++;
		end
		if (reset !== 1'b1) begin
			$display("reset was never released");
			errors++;
		end
		@(negedge CLOCK_50);
		compare("reset ledr", 32'd0, 32'(ledr));
		compare("reset column", 32'd0, 32'(column));
		compare("reset columnValid", 32'd0, 32'(columnValid));
		compare("reset hex0", 32'(7'b1000000), 32'(hex0));
		foreach (rows[r]) begin
			@(posedge CLOCK_50);
			sw <= rows[r].pattern;
			@(posedge CLOCK_50);
			@(negedge CLOCK_50);
			compare($sformatf("row %0d mirror", r), 32'(rows[r].pattern & ColumnMask), 32'(ledr));
			@(posedge CLOCK_50);
			loadPress <= 1'b1; // one cycle pulse
			@(posedge CLOCK_50);
			loadPress <= 1'b0;
			if (rows[r].accept) begin
				runAccepted(r);
			end else begin
				runRejected(r);
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/c4Pkg.sv
source/effectCtrlIf.sv
source/switchDecoder.sv
source/columnControl.sv
source/ledSequencer.sv
source/columnPort.sv
source/connectFourInput.sv
tb/clockGen.sv
tb/connectFourInput_sva.sv
tb/connectFourInput_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f compile.f --top-module connectFourInput_tb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "^TB PASSED$" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
